//--- files.f
source/ex_pkg.sv
source/ex_control.sv
source/ex_operand_reg.sv
source/serial_divider.sv
source/ex_alu.sv
source/store_align.sv
source/ex_stage.sv
verification/ex_stage_assert.sv
verification/tb_ex_stage.sv

//--- Makefile
LOG := sim.log

all:
	verilator --binary --timing --assert -f files.f --top-module tb_ex_stage -o Vtb_ex_stage
	./obj_dir/Vtb_ex_stage | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module tb_ex_stage

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all lint clean

//--- verification/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

    import ex_pkg::*;

    typedef struct packed {
        logic [4:0] op_bit;
        word_t      rj;
        word_t      rkd;
        word_t      imm;
        logic       src1_pc;
        logic       src2_imm;
        logic [2:0] store;     // byte, half, word.
        logic [2:0] load;      // byte, half, word.
        word_t      exp_result;
        byte_en_t   exp_we;
        word_t      exp_wdata;
    } entry_t;

    logic clk = 1'b0;
    logic reset, id_to_ex_valid, mem_allow_in;
    logic src1_is_pc, src2_is_imm, gr_we;
    logic load_byte, load_half, load_word, load_signed, store_byte, store_half, store_word;
    word_t pc, rj_value, rkd_value, imm;
    alu_op_t alu_op;
    reg_addr_t dest;
    logic ex_allow_in, ex_to_mem_valid, mem_gr_we, data_sram_en, forward_is_load;
    logic mem_load_byte, mem_load_half, mem_load_word, mem_load_signed;
    word_t mem_pc, mem_result, data_sram_addr, data_sram_wdata, forward_result;
    reg_addr_t mem_dest, forward_dest;
    byte_en_t data_sram_we;

    entry_t table_q[$];
    int     accept_cycle[$];
    int     cycle = 0;
    int     acc_cnt = 0;
    int     left_cnt = 0;

    ex_stage ex_stage_i (.*);

    always #10 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // the memory side is ready about three cycles out of four.
    always @(posedge clk) begin
        #2 mem_allow_in = reset ? 1'b0 : ($urandom % 4 != 0);
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp)
            fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_byte_en(input string name, input byte_en_t act, input byte_en_t exp);
        if (act !== exp)
            fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, act, exp));
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t act, input reg_addr_t exp);
        if (act !== exp)
            fail_run($sformatf("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp));
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp)
            fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, act, exp));
    endtask

    task automatic add(input int op, input word_t rj, input word_t rkd, input word_t im,
                       input logic s1, input logic s2, input logic [2:0] st,
                       input logic [2:0] ld, input word_t res, input byte_en_t we,
                       input word_t wd);
        table_q.push_back({op[4:0], rj, rkd, im, s1, s2, st, ld, res, we, wd});
    endtask

    function automatic word_t pc_of(input int i);
        return 32'h1c00_0000 + 4 * i;
    endfunction

    function automatic reg_addr_t dest_of(input int i);
        return reg_addr_t'((i % 31) + 1);
    endfunction

    task automatic build_table();
        add(OP_ADD,   32'h5,        32'h7,        0,      0, 0, 0, 0, 32'hc,        0, 32'h7);
        add(OP_SUB,   32'h3,        32'h5,        0,      0, 0, 0, 0, 32'hffff_fffe, 0, 32'h5);
        add(OP_SLT,   32'hffff_ffff, 32'h1,       0,      0, 0, 0, 0, 32'h1,        0, 32'h1);
        add(OP_SLTU,  32'hffff_ffff, 32'h1,       0,      0, 0, 0, 0, 32'h0,        0, 32'h1);
        add(OP_NOR,   32'h0f0f_0000, 32'h00f0_00f0, 0,    0, 0, 0, 0, 32'hf000_ff0f, 0, 32'h00f0_00f0);
        add(OP_AND,   32'hff00_ff00, 32'h0f0f_0f0f, 0,    0, 0, 0, 0, 32'h0f00_0f00, 0, 32'h0f0f_0f0f);
        add(OP_OR,    32'hff00_ff00, 32'h0f0f_0f0f, 0,    0, 0, 0, 0, 32'hff0f_ff0f, 0, 32'h0f0f_0f0f);
        add(OP_XOR,   32'hff00_ff00, 32'h0f0f_0f0f, 0,    0, 0, 0, 0, 32'hf00f_f00f, 0, 32'h0f0f_0f0f);
        add(OP_SLL,   32'h3,        32'h9,        32'h24, 0, 1, 0, 0, 32'h30,       0, 32'h9);
        add(OP_SRL,   32'h0,        32'h9,        32'h8,  1, 1, 0, 0, 32'h001c_0000, 0, 32'h9);
        add(OP_SRA,   32'h8000_0010, 32'h4,       0,      0, 0, 0, 0, 32'hf800_0001, 0, 32'h4);
        add(OP_LUI,   32'h0,        32'h0,        32'h1234_5000, 0, 1, 0, 0, 32'h1234_5000, 0, 0);
        add(OP_MUL,   32'h0001_0003, 32'h0002_0005, 0,    0, 0, 0, 0, 32'h000b_000f, 0, 32'h0002_0005);
        add(OP_MULH,  32'hffff_fffe, 32'h3,       0,      0, 0, 0, 0, 32'hffff_ffff, 0, 32'h3);
        add(OP_MULHU, 32'hffff_fffe, 32'h3,       0,      0, 0, 0, 0, 32'h2,        0, 32'h3);
        add(OP_DIV,   32'hffff_fff9, 32'h2,       0,      0, 0, 0, 0, 32'hffff_fffd, 0, 32'h2);
        add(OP_MOD,   32'hffff_fff9, 32'h2,       0,      0, 0, 0, 0, 32'hffff_ffff, 0, 32'h2);
        add(OP_DIVU,  32'hffff_fff9, 32'h2,       0,      0, 0, 0, 0, 32'h7fff_fffc, 0, 32'h2);
        add(OP_MODU,  32'hffff_fff9, 32'h2,       0,      0, 0, 0, 0, 32'h1,        0, 32'h2);
        add(OP_DIV,   32'h7,        32'hffff_fffe, 0,     0, 0, 0, 0, 32'hffff_fffd, 0, 32'hffff_fffe);
        add(OP_MOD,   32'h7,        32'hffff_fffe, 0,     0, 0, 0, 0, 32'h1,        0, 32'hffff_fffe);
        add(OP_DIVU,  32'h64,       32'h0,        0,      0, 0, 0, 0, 32'hffff_ffff, 0, 0);
        add(OP_MODU,  32'h64,       32'h0,        0,      0, 0, 0, 0, 32'h64,       0, 0);
        add(OP_MOD,   32'hffff_fff9, 32'h0,       0,      0, 0, 0, 0, 32'hffff_fff9, 0, 0);
        add(OP_DIV,   32'hffff_fff9, 32'h0,       0,      0, 0, 0, 0, 32'hffff_ffff, 0, 0);
        // store address is rj plus the immediate.
        add(OP_ADD, 32'h1000, 32'h1234_56a5, 32'h0, 0, 1, 3'b100, 0, 32'h1000, 4'b0001, 32'ha5a5_a5a5);
        add(OP_ADD, 32'h1000, 32'h1234_56a5, 32'h1, 0, 1, 3'b100, 0, 32'h1001, 4'b0010, 32'ha5a5_a5a5);
        add(OP_ADD, 32'h1000, 32'h1234_56a5, 32'h2, 0, 1, 3'b100, 0, 32'h1002, 4'b0100, 32'ha5a5_a5a5);
        add(OP_ADD, 32'h1000, 32'h1234_56a5, 32'h3, 0, 1, 3'b100, 0, 32'h1003, 4'b1000, 32'ha5a5_a5a5);
        add(OP_ADD, 32'h2000, 32'hdead_beef, 32'h0, 0, 1, 3'b010, 0, 32'h2000, 4'b0011, 32'hbeef_beef);
        add(OP_ADD, 32'h2000, 32'hdead_beef, 32'h2, 0, 1, 3'b010, 0, 32'h2002, 4'b1100, 32'hbeef_beef);
        add(OP_ADD, 32'h3000, 32'hcafe_f00d, 32'h0, 0, 1, 3'b001, 0, 32'h3000, 4'b1111, 32'hcafe_f00d);
        add(OP_ADD, 32'h4000, 32'h0,         32'h8, 0, 1, 0, 3'b001, 32'h4008, 0, 32'h0);
        add(OP_ADD, 32'h4000, 32'h0,         32'h3, 0, 1, 0, 3'b100, 32'h4003, 0, 32'h0);
    endtask

    task automatic drive_entry(input int i);
        entry_t e;
        e = table_q[i];
        id_to_ex_valid = 1'b1;
        pc          = pc_of(i);
        rj_value    = e.rj;
        rkd_value   = e.rkd;
        imm         = e.imm;
        alu_op      = alu_op_t'(1) << e.op_bit;
        src1_is_pc  = e.src1_pc;
        src2_is_imm = e.src2_imm;
        {store_byte, store_half, store_word} = e.store;
        {load_byte, load_half, load_word}    = e.load;
        load_signed = e.load[2];
        dest        = dest_of(i);
        gr_we       = ~i[0];
    endtask

    // sample in mid-cycle when inputs driven after the edge have settled.
    always @(negedge clk) begin
        entry_t e;
        if (!reset) begin
            if (acc_cnt == left_cnt) begin
                check_reg_addr("forward_dest", forward_dest, 5'd0);   // stage is empty.
                check_flag("data_sram_en", data_sram_en, 1'b0);
            end else begin
                check_reg_addr("forward_dest", forward_dest, dest_of(left_cnt));
            end
            if (ex_to_mem_valid) begin
                if (left_cnt >= table_q.size())
                    fail_run("an instruction left the stage that was never sent");
                e = table_q[left_cnt];
                check_word("mem_result", mem_result, e.exp_result);
                check_word("forward_result", forward_result, e.exp_result);
                check_word("mem_pc", mem_pc, pc_of(left_cnt));
                check_reg_addr("mem_dest", mem_dest, dest_of(left_cnt));
                check_flag("mem_gr_we", mem_gr_we, ~left_cnt[0]);
                check_flag("mem_load_byte", mem_load_byte, e.load[2]);
                check_flag("mem_load_half", mem_load_half, e.load[1]);
                check_flag("mem_load_word", mem_load_word, e.load[0]);
                check_flag("mem_load_signed", mem_load_signed, e.load[2]);
                check_flag("forward_is_load", forward_is_load, |e.load);
                check_flag("data_sram_en", data_sram_en, 1'b1);
                check_byte_en("data_sram_we", data_sram_we, e.exp_we);
                check_word("data_sram_addr", data_sram_addr, e.exp_result & ~32'h3);
                if (|e.store)
                    check_word("data_sram_wdata", data_sram_wdata, e.exp_wdata);
                // a divide is done 34 edges after the edge that accepted it.
                if (e.op_bit >= OP_DIV && cycle - accept_cycle[left_cnt] < 35)
                    fail_run($sformatf("divide %0d left the stage too early", left_cnt));
                if (mem_allow_in)
                    left_cnt++;
            end
            if (id_to_ex_valid && ex_allow_in) begin
                accept_cycle.push_back(cycle);
                acc_cnt++;
            end
        end
    end

    initial begin
        void'($urandom(44037));
        reset = 1'b1;
        mem_allow_in = 1'b0;
        id_to_ex_valid = 1'b0;
        {pc, rj_value, rkd_value, imm, alu_op, dest} = '0;
        {src1_is_pc, src2_is_imm, gr_we, load_signed} = '0;
        {load_byte, load_half, load_word, store_byte, store_half, store_word} = '0;
        build_table();
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            @(posedge clk);
            #2 drive_entry(i);
            do @(negedge clk); while (!ex_allow_in);
        end
        @(posedge clk);
        #2 id_to_ex_valid = 1'b0;
        wait (left_cnt == table_q.size());
        repeat (4) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    // the stage must drain within 80 cycles per entry.
    initial begin
        wait (table_q.size() != 0);
        #((table_q.size() * 80 + 8) * 20);
        fail_run("timeout, the stage stopped moving instructions");
    end

endmodule

//--- verification/ex_stage_assert.sv
`timescale 1ns/100ps

module ex_stage_assert (
    input logic              clk,
    input logic              reset,
    input logic              ex_to_mem_valid,
    input logic              mem_allow_in,
    input ex_pkg::word_t     mem_result,
    input ex_pkg::word_t     mem_pc,
    input ex_pkg::reg_addr_t mem_dest,
    input logic              data_sram_en,
    input ex_pkg::byte_en_t  data_sram_we,
    input ex_pkg::word_t     data_sram_addr
);

    // stage is empty right after a reset edge.
    reset_quiet: assert property (@(posedge clk) $past(reset) |-> !ex_to_mem_valid)
        else $error("ex_to_mem_valid high during reset");

    stall_stable: assert property (@(posedge clk) disable iff (reset)
        ex_to_mem_valid && !mem_allow_in |=> ex_to_mem_valid && $stable(mem_result)
            && $stable(mem_pc) && $stable(mem_dest) && $stable(data_sram_we)
            && $stable(data_sram_addr))
        else $error("execute outputs changed while stalled");

    no_write_idle: assert property (@(posedge clk) disable iff (reset)
        !data_sram_en |-> data_sram_we == 4'b0000)
        else $error("byte enables set without a memory request");

endmodule

bind ex_stage ex_stage_assert ex_stage_assert_i (.*);

//--- source/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              id_to_ex_valid,
    input  ex_pkg::word_t     pc,
    input  ex_pkg::word_t     rj_value,
    input  ex_pkg::word_t     rkd_value,
    input  ex_pkg::word_t     imm,
    input  ex_pkg::alu_op_t   alu_op,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  logic              load_byte,
    input  logic              load_half,
    input  logic              load_word,
    input  logic              load_signed,
    input  logic              store_byte,
    input  logic              store_half,
    input  logic              store_word,
    input  ex_pkg::reg_addr_t dest,
    input  logic              gr_we,
    output logic              ex_allow_in,
    output logic              ex_to_mem_valid,
    input  logic              mem_allow_in,
    output ex_pkg::word_t     mem_pc,
    output ex_pkg::word_t     mem_result,
    output logic              mem_load_byte,
    output logic              mem_load_half,
    output logic              mem_load_word,
    output logic              mem_load_signed,
    output ex_pkg::reg_addr_t mem_dest,
    output logic              mem_gr_we,
    output logic              data_sram_en,
    output ex_pkg::byte_en_t  data_sram_we,
    output ex_pkg::word_t     data_sram_addr,
    output ex_pkg::word_t     data_sram_wdata,
    output ex_pkg::reg_addr_t forward_dest,
    output ex_pkg::word_t     forward_result,
    output logic              forward_is_load
);

    import ex_pkg::*;

    logic      ex_valid;
    logic      latch_en;
    logic      op_done;
    logic      alu_wait;
    logic      load_any;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     alu_result;
    word_t     r_rkd_value;
    alu_op_t   r_alu_op;
    logic      r_store_byte;
    logic      r_store_half;
    logic      r_store_word;
    reg_addr_t r_dest;

    assign mem_result     = alu_result;
    assign forward_result = alu_result;
    assign mem_dest       = r_dest;

    ex_control control_i (
        .clk (clk), .reset (reset),
        .id_to_ex_valid (id_to_ex_valid), .mem_allow_in (mem_allow_in),
        .alu_wait (alu_wait), .dest (r_dest), .load_any (load_any),
        .ex_valid (ex_valid), .ex_allow_in (ex_allow_in),
        .ex_to_mem_valid (ex_to_mem_valid), .latch_en (latch_en), .op_done (op_done),
        .forward_dest (forward_dest), .forward_is_load (forward_is_load)
    );

    ex_operand_reg operand_reg_i (
        .clk (clk), .latch_en (latch_en),
        .pc (pc), .rj_value (rj_value), .rkd_value (rkd_value), .imm (imm),
        .alu_op (alu_op), .src1_is_pc (src1_is_pc), .src2_is_imm (src2_is_imm),
        .load_byte (load_byte), .load_half (load_half), .load_word (load_word),
        .load_signed (load_signed), .store_byte (store_byte), .store_half (store_half),
        .store_word (store_word), .dest (dest), .gr_we (gr_we),
        .r_pc (mem_pc), .r_rkd_value (r_rkd_value), .r_alu_op (r_alu_op),
        .r_load_byte (mem_load_byte), .r_load_half (mem_load_half),
        .r_load_word (mem_load_word), .r_load_signed (mem_load_signed),
        .r_store_byte (r_store_byte), .r_store_half (r_store_half),
        .r_store_word (r_store_word), .r_dest (r_dest), .r_gr_we (mem_gr_we),
        .alu_src1 (alu_src1), .alu_src2 (alu_src2), .load_any (load_any)
    );

    ex_alu alu_i (
        .clk (clk), .reset (reset),
        .alu_op (r_alu_op), .alu_src1 (alu_src1), .alu_src2 (alu_src2),
        .op_valid (ex_valid), .op_done (op_done),
        .alu_result (alu_result), .alu_wait (alu_wait)
    );

    store_align store_align_i (
        .ex_valid (ex_valid), .result (alu_result), .store_data (r_rkd_value),
        .store_byte (r_store_byte), .store_half (r_store_half), .store_word (r_store_word),
        .data_sram_en (data_sram_en), .data_sram_we (data_sram_we),
        .data_sram_addr (data_sram_addr), .data_sram_wdata (data_sram_wdata)
    );

endmodule

//--- source/store_align.sv
`timescale 1ns/100ps

module store_align (
    input  logic             ex_valid,
    input  ex_pkg::word_t    result,
    input  ex_pkg::word_t    store_data,
    input  logic             store_byte,
    input  logic             store_half,
    input  logic             store_word,
    output logic             data_sram_en,
    output ex_pkg::byte_en_t data_sram_we,
    output ex_pkg::word_t    data_sram_addr,
    output ex_pkg::word_t    data_sram_wdata
);

    assign data_sram_en   = ex_valid;
    assign data_sram_addr = {result[31:2], 2'b00};   // word aligned.

    always_comb begin
        data_sram_we = 4'b0000;
        if (ex_valid) begin
            if (store_byte) begin
                data_sram_we = 4'b0001 << result[1:0];
            end else if (store_half) begin
                data_sram_we = result[1] ? 4'b1100 : 4'b0011;
            end else if (store_word) begin
                data_sram_we = 4'b1111;
            end
        end
    end

    // replicate so every lane carries the data, byte enables pick the lane.
    assign data_sram_wdata = store_byte ? {4{store_data[7:0]}}
                           : store_half ? {2{store_data[15:0]}}
                           : store_data;

endmodule

//--- source/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  logic            clk,
    input  logic            reset,
    input  ex_pkg::alu_op_t alu_op,
    input  ex_pkg::word_t   alu_src1,
    input  ex_pkg::word_t   alu_src2,
    input  logic            op_valid,
    input  logic            op_done,
    output ex_pkg::word_t   alu_result,
    output logic            alu_wait
);

    import ex_pkg::*;

    logic               sub_like;
    word_t              adder_b;
    word_t              adder_sum;
    logic               adder_cout;
    logic               slt_result;
    logic               sltu_result;
    logic [4:0]         shamt;
    logic               mul_signed;
    logic signed [65:0] product;
    logic               is_div;
    logic               div_signed;
    logic               div_start;
    logic               div_busy;
    logic               div_done;
    word_t              quotient;
    word_t              remainder;

    // add, sub and both compares share one adder.
    assign sub_like = alu_op[OP_SUB] | alu_op[OP_SLT] | alu_op[OP_SLTU];
    assign adder_b  = sub_like ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, sub_like};

    assign slt_result  = (alu_src1[31] & ~alu_src2[31])
                       | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31]);
    assign sltu_result = ~adder_cout;   // borrow out.

    assign shamt = alu_src2[4:0];

    // one 33x33 signed multiplier covers signed and unsigned high words.
    assign mul_signed = alu_op[OP_MULH];
    assign product    = $signed({mul_signed & alu_src1[31], alu_src1})
                      * $signed({mul_signed & alu_src2[31], alu_src2});

    assign is_div     = alu_op[OP_DIV] | alu_op[OP_MOD] | alu_op[OP_DIVU] | alu_op[OP_MODU];
    assign div_signed = alu_op[OP_DIV] | alu_op[OP_MOD];
    assign div_start  = op_valid & is_div & ~div_busy & ~div_done;
    assign alu_wait   = op_valid & is_div & ~div_done;

    serial_divider divider_i (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .clear     (op_done),
        .signed_op (div_signed),
        .dividend  (alu_src1),
        .divisor   (alu_src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign alu_result = ({32{alu_op[OP_ADD] | alu_op[OP_SUB]}} & adder_sum)
                      | ({32{alu_op[OP_SLT]}}   & {31'd0, slt_result})
                      | ({32{alu_op[OP_SLTU]}}  & {31'd0, sltu_result})
                      | ({32{alu_op[OP_NOR]}}   & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[OP_AND]}}   & (alu_src1 & alu_src2))
                      | ({32{alu_op[OP_OR]}}    & (alu_src1 | alu_src2))
                      | ({32{alu_op[OP_XOR]}}   & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[OP_SLL]}}   & (alu_src1 << shamt))
                      | ({32{alu_op[OP_SRL]}}   & (alu_src1 >> shamt))
                      | ({32{alu_op[OP_SRA]}}   & word_t'($signed(alu_src1) >>> shamt))
                      | ({32{alu_op[OP_LUI]}}   & alu_src2)     // immediate already shifted.
                      | ({32{alu_op[OP_MUL]}}   & product[31:0])
                      | ({32{alu_op[OP_MULH] | alu_op[OP_MULHU]}} & product[63:32])
                      | ({32{alu_op[OP_DIV] | alu_op[OP_DIVU]}}   & quotient)
                      | ({32{alu_op[OP_MOD] | alu_op[OP_MODU]}}   & remainder);

endmodule

//--- source/serial_divider.sv
`timescale 1ns/100ps

module serial_divider (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  logic          clear,
    input  logic          signed_op,
    input  ex_pkg::word_t dividend,
    input  ex_pkg::word_t divisor,
    output logic          busy,
    output logic          done,
    output ex_pkg::word_t quotient,
    output ex_pkg::word_t remainder
);

    import ex_pkg::*;

    div_state_t  state;
    logic [5:0]  step_cnt;     // 0..31 shift-subtract, 32 is the sign fix.
    word_t       divisor_mag;
    word_t       quot;         // dividend bits shift out as quotient bits shift in.
    word_t       rem;
    logic        neg_quot;
    logic        neg_rem;
    logic        div_zero;
    logic [33:0] trial;

    assign trial = {1'b0, rem, quot[31]} - {2'b00, divisor_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else if (clear) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state    <= DIV_RUN;
                        step_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    if (step_cnt == 6'd32) state <= DIV_DONE;
                    step_cnt <= step_cnt + 6'd1;
                end
                DIV_DONE: state <= DIV_DONE;   // result held until cleared.
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            quot        <= (signed_op && dividend[31]) ? -dividend : dividend;
            divisor_mag <= (signed_op && divisor[31]) ? -divisor : divisor;
            rem         <= '0;
            neg_quot    <= signed_op & (dividend[31] ^ divisor[31]);
            neg_rem     <= signed_op & dividend[31];   // remainder follows the dividend.
            div_zero    <= (divisor == '0);
        end else if (state == DIV_RUN) begin
            if (step_cnt == 6'd32) begin
                quot <= div_zero ? '1 : (neg_quot ? -quot : quot);
                rem  <= neg_rem ? -rem : rem;
            end else if (!trial[33]) begin
                rem  <= trial[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= {rem[30:0], quot[31]};
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    assign busy      = (state == DIV_RUN);
    assign done      = (state == DIV_DONE);
    assign quotient  = quot;
    assign remainder = rem;

endmodule

//--- source/ex_operand_reg.sv
`timescale 1ns/100ps

module ex_operand_reg (
    input  logic              clk,
    input  logic              latch_en,
    input  ex_pkg::word_t     pc,
    input  ex_pkg::word_t     rj_value,
    input  ex_pkg::word_t     rkd_value,
    input  ex_pkg::word_t     imm,
    input  ex_pkg::alu_op_t   alu_op,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  logic              load_byte,
    input  logic              load_half,
    input  logic              load_word,
    input  logic              load_signed,
    input  logic              store_byte,
    input  logic              store_half,
    input  logic              store_word,
    input  ex_pkg::reg_addr_t dest,
    input  logic              gr_we,
    output ex_pkg::word_t     r_pc,
    output ex_pkg::word_t     r_rkd_value,
    output ex_pkg::alu_op_t   r_alu_op,
    output logic              r_load_byte,
    output logic              r_load_half,
    output logic              r_load_word,
    output logic              r_load_signed,
    output logic              r_store_byte,
    output logic              r_store_half,
    output logic              r_store_word,
    output ex_pkg::reg_addr_t r_dest,
    output logic              r_gr_we,
    output ex_pkg::word_t     alu_src1,
    output ex_pkg::word_t     alu_src2,
    output logic              load_any
);

    import ex_pkg::*;

    word_t r_rj_value;
    word_t r_imm;
    logic  r_src1_is_pc;
    logic  r_src2_is_imm;

    // the stage valid bit lives in ex_control.
    always_ff @(posedge clk) begin
        if (latch_en) begin
            r_pc          <= pc;
            r_rj_value    <= rj_value;
            r_rkd_value   <= rkd_value;
            r_imm         <= imm;
            r_alu_op      <= alu_op;
            r_src1_is_pc  <= src1_is_pc;
            r_src2_is_imm <= src2_is_imm;
            r_load_byte   <= load_byte;
            r_load_half   <= load_half;
            r_load_word   <= load_word;
            r_load_signed <= load_signed;
            r_store_byte  <= store_byte;
            r_store_half  <= store_half;
            r_store_word  <= store_word;
            r_dest        <= dest;
            r_gr_we       <= gr_we;
        end
    end

    assign alu_src1 = r_src1_is_pc  ? r_pc  : r_rj_value;
    assign alu_src2 = r_src2_is_imm ? r_imm : r_rkd_value;
    assign load_any = r_load_byte | r_load_half | r_load_word;

endmodule

//--- source/ex_control.sv
`timescale 1ns/100ps

module ex_control (
    input  logic              clk,
    input  logic              reset,
    input  logic              id_to_ex_valid,
    input  logic              mem_allow_in,
    input  logic              alu_wait,
    input  ex_pkg::reg_addr_t dest,
    input  logic              load_any,
    output logic              ex_valid,
    output logic              ex_allow_in,
    output logic              ex_to_mem_valid,
    output logic              latch_en,
    output logic              op_done,
    output ex_pkg::reg_addr_t forward_dest,
    output logic              forward_is_load
);

    logic ex_ready_go;

    // an empty stage is always ready, otherwise wait for the alu.
    assign ex_ready_go     = ~ex_valid | ~alu_wait;
    assign ex_allow_in     = ~ex_valid | (ex_ready_go & mem_allow_in);
    assign ex_to_mem_valid = ex_valid & ex_ready_go;

    assign latch_en = id_to_ex_valid & ex_allow_in;   // decode hands over an instruction.
    assign op_done  = ex_to_mem_valid & mem_allow_in; // current instruction leaves.

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (ex_allow_in) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    // a load still in execute has to stall the consumer in decode,
    // so the destination is published for loads as well.
    assign forward_dest    = ex_valid ? dest : '0;
    assign forward_is_load = ex_valid & load_any;

endmodule

//--- source/ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] word_t;      // pc, operands, result, address, store data.
    typedef logic [4:0]  reg_addr_t;  // general register number.
    typedef logic [18:0] alu_op_t;    // one-hot operation code.
    typedef logic [3:0]  byte_en_t;   // data memory byte-write enable.

    // bit positions inside alu_op_t.
    localparam int OP_ADD   = 0;
    localparam int OP_SUB   = 1;
    localparam int OP_SLT   = 2;
    localparam int OP_SLTU  = 3;
    localparam int OP_NOR   = 4;
    localparam int OP_AND   = 5;
    localparam int OP_OR    = 6;
    localparam int OP_XOR   = 7;
    localparam int OP_SLL   = 8;
    localparam int OP_SRL   = 9;
    localparam int OP_SRA   = 10;
    localparam int OP_LUI   = 11;
    localparam int OP_MUL   = 12;
    localparam int OP_MULH  = 13;
    localparam int OP_MULHU = 14;
    localparam int OP_DIV   = 15;
    localparam int OP_MOD   = 16;
    localparam int OP_DIVU  = 17;
    localparam int OP_MODU  = 18;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

endpackage
